// File: verilog.f
+incdir+verification
source/board_pkg.sv
source/esp_proto_pkg.sv
source/esp_cmd_if.sv
source/spi_slave.sv
source/cmd_parser.sv
source/cmd_exec.sv
source/esp_link_top.sv
verification/esp_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the ESP link testbench with Verilator and runs it
# the output is shown and searched for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module esp_link_tb \
    -f verilog.f -o esp_link_sim \
  && ./obj_dir/esp_link_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: verification/spi_master_tasks.svh
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// spi mode 0 master, msb first
// every pin change lands 1 ns after a rising clk edge

task automatic wait_clocks(input int n);
  repeat (n) begin
    @(posedge clk);
  end
  #1;
endtask

// open a frame and give the slave time to sync cs and load its answer
task automatic spi_begin();
  mosi = 1'b0;
  cs   = 1'b0;
  wait_clocks(CS_SETUP);
endtask

task automatic spi_end();
  wait_clocks(2);
  cs   = 1'b1;
  mosi = 1'b0;
  wait_clocks(BYTE_GAP);
endtask

// one sck period, miso sampled right before the rising edge
task automatic spi_shift_bit(input logic bit_out, output logic bit_in);
  mosi = bit_out;  // changes only while sck is low
  wait_clocks(SCK_HALF);
  bit_in = miso;
  sck = 1'b1;
  wait_clocks(SCK_HALF);
  sck = 1'b0;
endtask

task automatic spi_xfer(input byte_t tx, output byte_t rx);
  logic b;
  for (int i = 7; i >= 0; i--) begin
    spi_shift_bit(tx[i], b);
    rx[i] = b;
  end
  wait_clocks(BYTE_GAP);  // room for the answer to be ready
endtask

// only the top n bits, the frame is expected to be closed afterwards
task automatic spi_partial(input byte_t tx, input int n);
  logic b;
  for (int i = 0; i < n; i++) begin
    spi_shift_bit(tx[7 - i], b);
  end
endtask

`endif

// File: verification/esp_link_tb.sv
`timescale 1ns/10ps

module esp_link_tb;

  import board_pkg::*;
  import esp_proto_pkg::*;

  localparam int SCK_HALF        = 4;   // clk cycles per sck phase
  localparam int BYTE_GAP        = 16;  // idle clk cycles after a byte
  localparam int CS_SETUP        = 4;
  localparam int CYCLES_PER_BYTE = (8 * 8 + 16) * 2;

  typedef enum logic [1:0] {
    kind_get,      // answer comes back during a dummy byte
    kind_set,
    kind_ignored,  // unknown code
    kind_partial   // frame closed after four sck pulses
  } entry_kind_e;

  typedef struct packed {
    entry_kind_e kind;
    byte_t       cmd;
    logic [1:0]  nparams;
    byte_t       p0;
    byte_t       p1;
    byte_t       p2;
    conf_t       conf;
    byte_t       exp_answer;
    led_t        exp_led;
    rgb_t        exp_color;
  } entry_t;

  logic  clk;
  logic  rst;
  logic  cs;
  logic  sck;
  logic  mosi;
  logic  miso;
  conf_t conf;
  led_t  led;
  rgb_t  screen_color;

  entry_t      table_q[$];
  int unsigned lcg_state = 32'd60967;
  led_t        model_led;    // expected outputs while the table is built
  rgb_t        model_color;
  byte_t       model_tx;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  esp_link_top i_esp_link_top (
    .clk          (clk),
    .rst          (rst),
    .cs           (cs),
    .sck          (sck),
    .mosi         (mosi),
    .miso         (miso),
    .conf         (conf),
    .led          (led),
    .screen_color (screen_color)
  );

  always #4 clk = ~clk;

  `include "spi_master_tasks.svh"

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_color(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      fail_run($sformatf("timeout: the run did not finish within %0d clk cycles",
                         cycle_limit));
    end
  end

  // lcg, upper bits are the better ones
  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic void add_entry(input entry_kind_e kind, input byte_t cmd,
                                    input logic [1:0] nparams, input byte_t p0,
                                    input byte_t p1, input byte_t p2);
    entry_t e;
    byte_t  r;
    r         = rand_byte();
    e.kind    = kind;
    e.cmd     = cmd;
    e.nparams = nparams;
    e.p0      = p0;
    e.p1      = p1;
    e.p2      = p2;
    e.conf    = r[3:0];
    e.exp_answer = model_tx;
    if (kind == kind_get) begin
      if (cmd == CMD_GET_COOKIE) begin
        e.exp_answer = 8'hAF;
      end else if (cmd == CMD_GET_VERSION) begin
        e.exp_answer = 8'h03;
      end else begin
        e.exp_answer = {4'b0000, e.conf};
      end
    end else if (kind == kind_set) begin
      if (cmd == CMD_SET_LED) begin
        model_led = p0[2:0];
      end else begin
        model_color = {p0, p1, p2};
      end
    end
    if (kind == kind_get || kind == kind_ignored) begin
      model_tx = 8'hAF;  // the dummy byte is a get_cookie
    end
    e.exp_led   = model_led;
    e.exp_color = model_color;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    byte_t r;
    byte_t g;
    byte_t b;
    model_led   = '0;
    model_color = 24'hFFFFFF;
    model_tx    = '0;
    add_entry(kind_get, CMD_GET_COOKIE, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_get, CMD_GET_VERSION, 2'd0, 8'h00, 8'h00, 8'h00);
    repeat (3) begin
      add_entry(kind_get, CMD_GET_CONFIG, 2'd0, 8'h00, 8'h00, 8'h00);
    end
    add_entry(kind_set, CMD_SET_LED, 2'd1, rand_byte(), 8'h00, 8'h00);
    add_entry(kind_get, CMD_GET_COOKIE, 2'd0, 8'h00, 8'h00, 8'h00);
    r = rand_byte();
    g = rand_byte();
    b = rand_byte();
    add_entry(kind_set, CMD_SET_SCREEN_COLOR, 2'd3, r, g, b);
    add_entry(kind_get, CMD_GET_VERSION, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_set, CMD_SET_LED, 2'd1, rand_byte(), 8'h00, 8'h00);
    add_entry(kind_get, CMD_GET_CONFIG, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_ignored, 8'd99, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_get, CMD_GET_VERSION, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_partial, 8'hFF, 2'd0, 8'h00, 8'h00, 8'h00);
    r = rand_byte();
    g = rand_byte();
    b = rand_byte();
    add_entry(kind_set, CMD_SET_SCREEN_COLOR, 2'd3, r, g, b);
    add_entry(kind_get, CMD_GET_CONFIG, 2'd0, 8'h00, 8'h00, 8'h00);
    add_entry(kind_set, CMD_SET_LED, 2'd1, rand_byte(), 8'h00, 8'h00);
    add_entry(kind_get, CMD_GET_COOKIE, 2'd0, 8'h00, 8'h00, 8'h00);
  endfunction

  function automatic int count_bytes();
    int n;
    n = 0;
    foreach (table_q[i]) begin
      case (table_q[i].kind)
        kind_set:     n = n + 1 + int'(table_q[i].nparams);
        kind_partial: n = n + 1;
        default:      n = n + 2;  // command plus dummy byte
      endcase
    end
    return n;
  endfunction

  task automatic apply_entry(input entry_t e);
    byte_t rx;
    conf = e.conf;
    spi_begin();
    if (e.kind == kind_partial) begin
      spi_partial(e.cmd, 4);
    end else begin
      spi_xfer(e.cmd, rx);
      if (e.nparams >= 2'd1) begin
        spi_xfer(e.p0, rx);
      end
      if (e.nparams >= 2'd2) begin
        spi_xfer(e.p1, rx);
      end
      if (e.nparams >= 2'd3) begin
        spi_xfer(e.p2, rx);
      end
      if (e.kind == kind_get || e.kind == kind_ignored) begin
        spi_xfer(CMD_GET_COOKIE, rx);
        check_byte(rx, e.exp_answer, $sformatf("answer to command %h", e.cmd));
      end
    end
    spi_end();
    check_led(led, e.exp_led, "led");
    check_color(screen_color, e.exp_color, "screen_color");
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    cs   = 1'b1;
    sck  = 1'b0;
    mosi = 1'b0;
    conf = '0;
    build_table();
    cycle_limit = count_bytes() * CYCLES_PER_BYTE;
    wait_clocks(10);
    rst = 1'b0;
    wait_clocks(2);
    check_color(screen_color, 24'hFFFFFF, "screen_color after reset");
    check_led(led, 3'b000, "led after reset");
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: source/esp_link_top.sv
`timescale 1ns/10ps

module esp_link_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              cs,
  input  logic              sck,
  input  logic              mosi,
  output logic              miso,
  input  board_pkg::conf_t  conf,
  output board_pkg::led_t   led,
  output board_pkg::rgb_t   screen_color
);

  import board_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  byte_t tx_byte;  // answer for the next exchange

  esp_cmd_if cmd_bus ();

  spi_slave i_spi_slave (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .sck      (sck),
    .mosi     (mosi),
    .miso     (miso),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .tx_byte  (tx_byte)
  );

  cmd_parser i_cmd_parser (
    .clk      (clk),
    .rst      (rst),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .cmd_bus  (cmd_bus.parser)
  );

  cmd_exec i_cmd_exec (
    .clk          (clk),
    .rst          (rst),
    .cmd_bus      (cmd_bus.exec),
    .conf         (conf),
    .tx_byte      (tx_byte),
    .led          (led),
    .screen_color (screen_color)
  );

endmodule

// File: source/cmd_exec.sv
`timescale 1ns/10ps

module cmd_exec (
  input  logic              clk,
  input  logic              rst,
  esp_cmd_if.exec           cmd_bus,
  input  board_pkg::conf_t  conf,
  output board_pkg::byte_t  tx_byte,
  output board_pkg::led_t   led,
  output board_pkg::rgb_t   screen_color
);

  import board_pkg::*;
  import esp_proto_pkg::*;

  byte_t version_byte;

  assign version_byte = {VERSION_MAJOR, VERSION_MINOR};

  // get commands load the answer, set commands update the outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_byte      <= '0;
      led          <= '0;
      screen_color <= '1;  // white screen
    end else if (cmd_bus.trigger) begin
      case (cmd_bus.cmd)
        CMD_GET_COOKIE: begin
          tx_byte <= COOKIE;
        end
        CMD_GET_VERSION: begin
          tx_byte <= version_byte;
        end
        CMD_GET_CONFIG: begin
          tx_byte <= byte_t'(conf);  // zero-extended
        end
        CMD_SET_LED: begin
          led <= cmd_bus.param0[$bits(led_t) - 1:0];
        end
        CMD_SET_SCREEN_COLOR: begin
          screen_color <= {cmd_bus.param0, cmd_bus.param1, cmd_bus.param2};
        end
        default: begin
          // nothing to do
        end
      endcase
    end
  end

endmodule

// File: source/cmd_parser.sv
`timescale 1ns/10ps

module cmd_parser (
  input  logic             clk,
  input  logic             rst,
  input  board_pkg::byte_t rx_byte,
  input  logic             rx_valid,
  esp_cmd_if.parser        cmd_bus
);

  import board_pkg::*;
  import esp_proto_pkg::*;

  typedef enum logic {
    idle,
    read_bytes
  } parser_state_e;

  parser_state_e state;
  param_cnt_t    remaining;    // parameter bytes still to come
  param_cnt_t    idx;          // slot for the next parameter
  param_cnt_t    param_count;
  logic          cmd_known;

  // parameter count of the byte just received, used in idle
  always_comb begin
    cmd_known   = 1'b1;
    param_count = '0;
    case (rx_byte)
      CMD_GET_COOKIE,
      CMD_GET_VERSION,
      CMD_GET_CONFIG:       param_count = '0;
      CMD_SET_LED:          param_count = param_cnt_t'(1);
      CMD_SET_SCREEN_COLOR: param_count = param_cnt_t'(MAX_PARAMS);
      default:              cmd_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= idle;
      remaining       <= '0;
      idx             <= '0;
      cmd_bus.trigger <= 1'b0;
    end else begin
      cmd_bus.trigger <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            idx <= '0;
            if (cmd_known) begin
              if (param_count == '0) begin
                cmd_bus.trigger <= 1'b1;  // no params, fire now
              end else begin
                remaining <= param_count;
                state     <= read_bytes;
              end
            end
          end
          read_bytes: begin
            idx       <= idx + param_cnt_t'(1);
            remaining <= remaining - param_cnt_t'(1);
            if (remaining == param_cnt_t'(1)) begin
              cmd_bus.trigger <= 1'b1;
              state           <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // command and parameter bytes
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == idle) begin
        cmd_bus.cmd <= rx_byte;
      end else begin
        case (idx)
          param_cnt_t'(0): cmd_bus.param0 <= rx_byte;
          param_cnt_t'(1): cmd_bus.param1 <= rx_byte;
          default:         cmd_bus.param2 <= rx_byte;
        endcase
      end
    end
  end

endmodule

// File: source/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
  input  logic             clk,
  input  logic             rst,
  input  logic             cs,
  input  logic             sck,
  input  logic             mosi,
  output logic             miso,
  output board_pkg::byte_t rx_byte,
  output logic             rx_valid,
  input  board_pkg::byte_t tx_byte
);

  import board_pkg::*;

  logic [2:0] sck_sync;   // two sync stages plus one for the edge detector
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      tx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync  <= 2'b11;  // deselected
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      cs_sync  <= {cs_sync[0], cs};
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  // bit counter and byte strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // drops a partial byte
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
    end
  end

  // answer is reloaded between bytes so bit 7 is out before the first rising edge
  always_ff @(posedge clk) begin
    if (cs_active) begin
      if (bit_cnt == 3'd0) begin
        tx_shift <= tx_byte;
      end else if (sck_fall) begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'b0;

endmodule

// File: source/esp_cmd_if.sv
`timescale 1ns/10ps

interface esp_cmd_if;

  board_pkg::byte_t cmd;
  board_pkg::byte_t param0;
  board_pkg::byte_t param1;
  board_pkg::byte_t param2;
  logic             trigger;  // one cycle, cmd and params valid with it

  modport parser (
    output cmd,
    output param0,
    output param1,
    output param2,
    output trigger
  );

  modport exec (
    input cmd,
    input param0,
    input param1,
    input param2,
    input trigger
  );

endinterface

// File: source/esp_proto_pkg.sv
package esp_proto_pkg;

  // command codes sent by the esp as the first byte of a command
  localparam board_pkg::byte_t CMD_GET_COOKIE       = 8'd0;
  localparam board_pkg::byte_t CMD_GET_VERSION      = 8'd15;
  localparam board_pkg::byte_t CMD_SET_SCREEN_COLOR = 8'd17;  // 3 params, r g b
  localparam board_pkg::byte_t CMD_SET_LED          = 8'd26;  // 1 param
  localparam board_pkg::byte_t CMD_GET_CONFIG       = 8'd27;

  // answer to get_cookie, lets the esp detect the fpga
  localparam board_pkg::byte_t COOKIE = 8'hAF;

  // version byte is {major, minor}
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

endpackage

// File: source/board_pkg.sv
package board_pkg;

  // one spi byte or one command parameter
  typedef logic [7:0] byte_t;

  typedef logic [23:0] rgb_t;  // red in top byte, then green, then blue

  typedef logic [2:0] led_t;   // bit0 red, bit1 green, bit2 blue

  typedef logic [3:0] conf_t;  // board config switches

  // largest parameter count of any supported command
  localparam int MAX_PARAMS = 3;

  // wide enough to count 0 .. MAX_PARAMS
  typedef logic [$clog2(MAX_PARAMS + 1) - 1:0] param_cnt_t;

endpackage
